//--- idec_top.f
+incdir+design
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/idec_control.sv
design/idec_hazard.sv
design/idec_imm_gen.sv
design/idec_stage_reg.sv
design/idec_top.sv
verification/tb_idec_top.sv

//--- Bender.yml
package:
  name: idec_top

sources:
  - include_dirs:
      - design
    files:
      - design/mips_isa_pkg.sv
      - design/mips_pipe_pkg.sv
      - design/idec_control.sv
      - design/idec_hazard.sv
      - design/idec_imm_gen.sv
      - design/idec_stage_reg.sv
      - design/idec_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/tb_idec_top.sv

//--- verification/tb_idec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "idec_config.svh"

module tb_idec_top;

  localparam int NUM_INST       = 2000;
  localparam int TIMEOUT_CYCLES = NUM_INST + NUM_INST / 4;  // rare stalls plus reset

  // primary opcodes beyond SPECIAL/REGIMM/SPECIAL3 plus the no-op cases 1c and 3f
  localparam logic [24*6-1:0] OP_TBL = {6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09,
                                        6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21,
                                        6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b, 6'h1c, 6'h3f};
  // kept SPECIAL functs plus funct 1 which is not kept
  localparam logic [21*6-1:0] FN_TBL = {6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7, 6'd8, 6'd9, 6'd10,
                                        6'd11, 6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38,
                                        6'd39, 6'd42, 6'd43, 6'd1};

  typedef struct packed {
    mips_pipe_pkg::id_ctrl_t ctrl;
    mips_pipe_pkg::src_use_t src;
    logic [`IDEC_XLEN-1:0]   imm;
  } ref_dec_t;

  logic                        clock;
  logic                        arst_n;
  logic [`IDEC_XLEN-1:0]       inst_word;
  logic [`IDEC_XLEN-1:0]       pc_plus_4;
  logic [`IDEC_XLEN-1:0]       rf_rd_data1;
  logic [`IDEC_XLEN-1:0]       rf_rd_data2;
  mips_pipe_pkg::dest_t        ex_mem_dest;
  logic [`IDEC_REG_ADDR_W-1:0] rf_rd_addr1;
  logic [`IDEC_REG_ADDR_W-1:0] rf_rd_addr2;
  logic                        stall;
  mips_pipe_pkg::id_ctrl_t     ex_ctrl;
  mips_pipe_pkg::id_opnd_t     ex_opnd;

  logic [31:0]             seed;
  int                      errors;
  int                      checks;
  int                      stalls;
  int                      issued;
  int                      cycles;
  logic                    hold_inst;
  logic                    exp_bubble;
  logic                    exp_stall;
  mips_pipe_pkg::id_ctrl_t exp_ctrl;
  mips_pipe_pkg::id_opnd_t exp_opnd;
  mips_pipe_pkg::fwd_t     exp_a_fwd;
  mips_pipe_pkg::fwd_t     exp_b_fwd;
  ref_dec_t                cur;

  idec_top uut (
    .clock       (clock),
    .arst_n      (arst_n),
    .inst_word   (inst_word),
    .pc_plus_4   (pc_plus_4),
    .rf_rd_data1 (rf_rd_data1),
    .rf_rd_data2 (rf_rd_data2),
    .ex_mem_dest (ex_mem_dest),
    .rf_rd_addr1 (rf_rd_addr1),
    .rf_rd_addr2 (rf_rd_addr2),
    .stall       (stall),
    .ex_ctrl     (ex_ctrl),
    .ex_opnd     (ex_opnd)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // upper halves of two lcg steps
  task automatic draw(output logic [31:0] v);
    seed = lcg_next(seed);
    v[31:16] = seed[31:16];
    seed = lcg_next(seed);
    v[15:0] = seed[31:16];
  endtask

  task automatic next_inst(output logic [31:0] w);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [5:0]  opc;
    logic [5:0]  fn;
    draw(r1);
    draw(r2);
    fn  = FN_TBL[(r1[15:8] % 21) * 6 +: 6];
    opc = OP_TBL[(r1[15:8] % 24) * 6 +: 6];
    case (r1[1:0])
      2'd0: w = {6'h00, 2'b00, r2[2:0], 2'b00, r2[5:3], 2'b00, r2[8:6],
                 (fn == 6'd0 || fn == 6'd2 || fn == 6'd3) ? r2[13:9] : 5'd0, fn};
      2'd1: begin
        if (r1[2])
          w = {6'h01, 2'b00, r2[2:0], r1[3], 2'b00, r1[5] & r1[6], r1[4],
               r2[31:16]};  // bltz..bgezal or an unused rt
        else
          w = {6'h1f, 5'd0, 2'b00, r2[5:3], 2'b00, r2[8:6],
               (r1[5] && r1[6]) ? 5'd0 : (r1[3] ? 5'd24 : 5'd16), 6'd32};
      end
      default: begin
        if (opc == 6'h02 || opc == 6'h03)
          w = {opc, r2[25:0]};
        else
          w = {opc, 2'b00, r2[2:0], 2'b00, r2[5:3], r2[31:16]};
      end
    endcase
  endtask

  task automatic drive_inputs;
    logic [31:0] r;
    if (!hold_inst) begin
      next_inst(inst_word);
      draw(r);
      pc_plus_4 = {r[31:2], 2'b00};
      issued++;
    end
    draw(rf_rd_data1);
    draw(rf_rd_data2);
    draw(r);
    ex_mem_dest.addr  = {2'b00, r[2:0]};
    ex_mem_dest.valid = r[3] && (r[2:0] != 3'd0);
  endtask

  function automatic ref_dec_t ref_decode(input logic [31:0] w, input logic [31:0] pc4);
    ref_dec_t    e;
    logic [5:0]  opc;
    logic [5:0]  fn;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [31:0] sx;
    logic        sext;
    logic        ok;
    opc  = w[31:26];
    rt   = w[20:16];
    rd   = w[15:11];
    sa   = w[10:6];
    fn   = w[5:0];
    sx   = {{16{w[15]}}, w[15:0]};
    e    = '0;
    sext = 1'b0;
    ok   = 1'b1;
    e.src.a_addr = w[25:21];
    e.src.b_addr = rt;
    case (opc)
      6'h00: begin
        e.ctrl.alu_inst = 1'b1;
        e.ctrl.shamt    = sa;
        e.ctrl.dest     = '{addr: rd, valid: 1'b1};
        e.src.a_used    = !(fn == 6'd0 || fn == 6'd2 || fn == 6'd3);
        e.src.b_used    = 1'b1;
        case (fn)
          6'd0, 6'd4:   e.ctrl.alu_op = mips_pipe_pkg::ALU_SLL;
          6'd2, 6'd6:   e.ctrl.alu_op = mips_pipe_pkg::ALU_SRL;
          6'd3, 6'd7:   e.ctrl.alu_op = mips_pipe_pkg::ALU_SRA;
          6'd10:        e.ctrl.alu_op = mips_pipe_pkg::ALU_MOVZ;
          6'd11:        e.ctrl.alu_op = mips_pipe_pkg::ALU_MOVN;
          6'd32, 6'd33: e.ctrl.alu_op = mips_pipe_pkg::ALU_ADD;
          6'd34, 6'd35: e.ctrl.alu_op = mips_pipe_pkg::ALU_SUB;
          6'd36:        e.ctrl.alu_op = mips_pipe_pkg::ALU_AND;
          6'd37:        e.ctrl.alu_op = mips_pipe_pkg::ALU_OR;
          6'd38:        e.ctrl.alu_op = mips_pipe_pkg::ALU_XOR;
          6'd39:        e.ctrl.alu_op = mips_pipe_pkg::ALU_NOR;
          6'd42, 6'd43: begin
            e.ctrl.alu_op      = mips_pipe_pkg::ALU_SUB;
            e.ctrl.alu_res_sel = mips_pipe_pkg::RES_SET;
            e.ctrl.alu_set_u   = (fn == 6'd43);
          end
          6'd8, 6'd9: begin
            e.ctrl.alu_inst   = 1'b0;
            e.ctrl.jmp_inst   = 1'b1;
            e.ctrl.dest.valid = (fn == 6'd9);  // jalr
            e.src.b_used      = 1'b0;
          end
          default: ok = 1'b0;
        endcase
      end
      6'h01: begin
        e.ctrl.branch_inst = 1'b1;
        e.ctrl.branch_cond = rt[0] ? mips_pipe_pkg::COND_GE : mips_pipe_pkg::COND_LT;
        e.ctrl.dest        = '{addr: 5'd`IDEC_LINK_REG, valid: rt[4]};
        e.src.a_used       = 1'b1;
        ok = (rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17);
      end
      6'h02, 6'h03: begin
        e.ctrl.jmp_inst = 1'b1;
        e.ctrl.dest     = '{addr: 5'd`IDEC_LINK_REG, valid: (opc == 6'h03)};
      end
      6'h04, 6'h05, 6'h06, 6'h07: begin
        e.ctrl.branch_inst = 1'b1;
        e.src.a_used       = 1'b1;
        e.src.b_used       = (opc == 6'h04 || opc == 6'h05);
        case (opc)
          6'h04:   e.ctrl.branch_cond = mips_pipe_pkg::COND_EQ;
          6'h05:   e.ctrl.branch_cond = mips_pipe_pkg::COND_NE;
          6'h06:   e.ctrl.branch_cond = mips_pipe_pkg::COND_LE;
          default: e.ctrl.branch_cond = mips_pipe_pkg::COND_GT;
        endcase
      end
      6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
        e.ctrl.alu_inst = 1'b1;
        e.ctrl.dest     = '{addr: rt, valid: 1'b1};
        e.src.a_used    = (opc != 6'h0f);
        sext            = (opc <= 6'h0b);  // addi, addiu, slti, sltiu
        case (opc)
          6'h08, 6'h09: e.ctrl.alu_op = mips_pipe_pkg::ALU_ADD;
          6'h0c:        e.ctrl.alu_op = mips_pipe_pkg::ALU_AND;
          6'h0d:        e.ctrl.alu_op = mips_pipe_pkg::ALU_OR;
          6'h0e:        e.ctrl.alu_op = mips_pipe_pkg::ALU_XOR;
          6'h0f:        e.ctrl.alu_op = mips_pipe_pkg::ALU_LUI;
          default: begin
            e.ctrl.alu_op      = mips_pipe_pkg::ALU_SUB;
            e.ctrl.alu_res_sel = mips_pipe_pkg::RES_SET;
            e.ctrl.alu_set_u   = (opc == 6'h0b);
          end
        endcase
      end
      6'h1f: begin
        e.ctrl.alu_inst = 1'b1;
        e.ctrl.dest     = '{addr: rd, valid: 1'b1};
        e.src.b_used    = 1'b1;
        if (fn == 6'd32 && sa == 5'd16)
          e.ctrl.alu_op = mips_pipe_pkg::ALU_SEB;
        else if (fn == 6'd32 && sa == 5'd24)
          e.ctrl.alu_op = mips_pipe_pkg::ALU_SEH;
        else
          ok = 1'b0;
      end
      6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b: begin
        e.ctrl.alu_op = mips_pipe_pkg::ALU_ADD;
        e.src.a_used  = 1'b1;
        sext          = 1'b1;
        if (opc == 6'h20 || opc == 6'h24 || opc == 6'h28)
          e.ctrl.ls_op = mips_pipe_pkg::LS_BYTE;
        else if (opc == 6'h21 || opc == 6'h25 || opc == 6'h29)
          e.ctrl.ls_op = mips_pipe_pkg::LS_HALFWORD;
        else
          e.ctrl.ls_op = mips_pipe_pkg::LS_WORD;
        if (opc >= 6'h28) begin  // stores
          e.ctrl.store_inst  = 1'b1;
          e.ctrl.b_need_late = 1'b1;
          e.src.b_used       = 1'b1;
          e.src.b_late       = 1'b1;
        end else begin
          e.ctrl.load_inst = 1'b1;
          e.ctrl.ls_sext   = (opc == 6'h20 || opc == 6'h21);
          e.ctrl.dest      = '{addr: rt, valid: 1'b1};
        end
      end
      default: ok = 1'b0;
    endcase
    if (e.ctrl.dest.addr == 5'd0)
      e.ctrl.dest.valid = 1'b0;
    if (!ok) begin
      e    = '0;
      sext = 1'b0;
    end
    e.ctrl.imm_valid = !(opc == 6'h00 || opc == 6'h1c || opc == 6'h1f);
    if (e.ctrl.jmp_inst)
      e.imm = {pc4[31:28], w[25:0], 2'b00};
    else if (e.ctrl.branch_inst)
      e.imm = pc4 + (sx << 2);
    else
      e.imm = sext ? sx : {16'h0000, w[15:0]};
    return e;
  endfunction

  function automatic logic matches_dest(input logic used, input logic [4:0] addr,
                                        input mips_pipe_pkg::dest_t d);
    return used && d.valid && (addr == d.addr);
  endfunction

  task automatic expect_hazard(input  mips_pipe_pkg::src_use_t s,
                               input  mips_pipe_pkg::dest_t    ex_d,
                               input  logic                    ex_ld,
                               input  mips_pipe_pkg::dest_t    mem_d,
                               output mips_pipe_pkg::fwd_t     a,
                               output mips_pipe_pkg::fwd_t     b,
                               output logic                    st);
    logic a_ex;
    logic b_ex;
    a_ex = matches_dest(s.a_used, s.a_addr, ex_d);
    b_ex = matches_dest(s.b_used, s.b_addr, ex_d);
    if (a_ex)
      a = mips_pipe_pkg::FWD_FROM_EXMEM;
    else if (matches_dest(s.a_used, s.a_addr, mem_d))
      a = mips_pipe_pkg::FWD_FROM_MEMWB;
    else
      a = mips_pipe_pkg::FWD_NONE;
    if (b_ex)
      b = ex_ld ? mips_pipe_pkg::FWD_FROM_MEMWB_LATE : mips_pipe_pkg::FWD_FROM_EXMEM;
    else if (matches_dest(s.b_used, s.b_addr, mem_d))
      b = mips_pipe_pkg::FWD_FROM_MEMWB;
    else
      b = mips_pipe_pkg::FWD_NONE;
    st = ex_ld && (a_ex || (b_ex && !s.b_late));
  endtask

  task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_stage;
    if (exp_bubble) begin
      check_value("ex_ctrl", ex_ctrl, '0);
      check_value("ex_opnd", ex_opnd, '0);
    end else begin
      check_value("alu_op", ex_ctrl.alu_op, exp_ctrl.alu_op);
      check_value("alu_res_sel", ex_ctrl.alu_res_sel, exp_ctrl.alu_res_sel);
      check_value("alu_set_u", ex_ctrl.alu_set_u, exp_ctrl.alu_set_u);
      check_value("ls_op", ex_ctrl.ls_op, exp_ctrl.ls_op);
      check_value("ls_sext", ex_ctrl.ls_sext, exp_ctrl.ls_sext);
      check_value("branch_cond", ex_ctrl.branch_cond, exp_ctrl.branch_cond);
      check_value("class_flags", {ex_ctrl.alu_inst, ex_ctrl.load_inst, ex_ctrl.store_inst,
                  ex_ctrl.jmp_inst, ex_ctrl.branch_inst}, {exp_ctrl.alu_inst,
                  exp_ctrl.load_inst, exp_ctrl.store_inst, exp_ctrl.jmp_inst,
                  exp_ctrl.branch_inst});
      check_value("dest.valid", ex_ctrl.dest.valid, exp_ctrl.dest.valid);
      if (exp_ctrl.dest.valid)
        check_value("dest.addr", ex_ctrl.dest.addr, exp_ctrl.dest.addr);
      check_value("shamt", ex_ctrl.shamt, exp_ctrl.shamt);
      check_value("a_fwd", ex_ctrl.a_fwd, exp_ctrl.a_fwd);
      check_value("b_fwd", ex_ctrl.b_fwd, exp_ctrl.b_fwd);
      check_value("b_need_late", ex_ctrl.b_need_late, exp_ctrl.b_need_late);
      check_value("imm_valid", ex_ctrl.imm_valid, exp_ctrl.imm_valid);
      check_value("opnd.a", ex_opnd.a, exp_opnd.a);
      check_value("opnd.b", ex_opnd.b, exp_opnd.b);
      check_value("opnd.imm", ex_opnd.imm, exp_opnd.imm);
    end
  endtask

  // outputs are read before the edge updates them
  always @(posedge clock) begin
    if (arst_n) begin
      compare_stage();
      cur = ref_decode(inst_word, pc_plus_4);
      expect_hazard(cur.src, exp_ctrl.dest, exp_ctrl.load_inst, ex_mem_dest,
                    exp_a_fwd, exp_b_fwd, exp_stall);
      check_value("stall", stall, exp_stall);
      check_value("rf_rd_addr1", rf_rd_addr1, inst_word[25:21]);
      check_value("rf_rd_addr2", rf_rd_addr2, inst_word[20:16]);
      hold_inst  = stall;
      exp_bubble = exp_stall;
      if (exp_stall) begin
        stalls++;
        exp_ctrl = '0;
        exp_opnd = '0;
      end else begin
        exp_ctrl       = cur.ctrl;
        exp_ctrl.a_fwd = exp_a_fwd;
        exp_ctrl.b_fwd = exp_b_fwd;
        exp_opnd       = '{a: rf_rd_data1, b: rf_rd_data2, imm: cur.imm};
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    seed        = 32'h15af_7623;
    errors      = 0;
    checks      = 0;
    stalls      = 0;
    issued      = 0;
    cycles      = 0;
    hold_inst   = 1'b0;
    exp_bubble  = 1'b1;  // reset value is all zero
    exp_ctrl    = '0;
    exp_opnd    = '0;
    arst_n      = 1'b0;
    inst_word   = '0;
    pc_plus_4   = '0;
    rf_rd_data1 = '0;
    rf_rd_data2 = '0;
    ex_mem_dest = '0;
    repeat (8) @(negedge clock);
    arst_n = 1'b1;
    while (issued < NUM_INST || hold_inst) begin
      drive_inputs();
      @(negedge clock);
    end
    repeat (2) @(negedge clock);  // last result reaches ID/EX
    if (stalls == 0) begin
      errors++;
      $display("no load-use stall was exercised");
    end
    $display("checks %0d, errors %0d, stalls %0d", checks, errors, stalls);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/idec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "idec_config.svh"

module idec_top (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic [`IDEC_XLEN-1:0]       inst_word,
  input  logic [`IDEC_XLEN-1:0]       pc_plus_4,
  input  logic [`IDEC_XLEN-1:0]       rf_rd_data1,
  input  logic [`IDEC_XLEN-1:0]       rf_rd_data2,
  input  mips_pipe_pkg::dest_t        ex_mem_dest,
  output logic [`IDEC_REG_ADDR_W-1:0] rf_rd_addr1,
  output logic [`IDEC_REG_ADDR_W-1:0] rf_rd_addr2,
  output logic                        stall,
  output mips_pipe_pkg::id_ctrl_t     ex_ctrl,
  output mips_pipe_pkg::id_opnd_t     ex_opnd
);

  mips_isa_pkg::inst_fields_t fields;
  mips_pipe_pkg::id_ctrl_t    ctrl_dec;
  mips_pipe_pkg::id_ctrl_t    ctrl_d;
  mips_pipe_pkg::id_opnd_t    opnd_d;
  mips_pipe_pkg::src_use_t    src_use;
  mips_pipe_pkg::fwd_t        a_fwd;
  mips_pipe_pkg::fwd_t        b_fwd;
  logic                       imm_sext;
  logic [`IDEC_XLEN-1:0]      imm;

  assign fields = inst_word;

  // raw rs/rt, unused reads are harmless
  assign rf_rd_addr1 = fields.rs;
  assign rf_rd_addr2 = fields.rt;

  idec_control u_control (
    .inst_word (inst_word),
    .ctrl_dec  (ctrl_dec),
    .src_use   (src_use),
    .imm_sext  (imm_sext)
  );

  idec_hazard u_hazard (
    .src_use     (src_use),
    .ex_dest     (ex_ctrl.dest),  // instruction now in EX
    .ex_load     (ex_ctrl.load_inst),
    .ex_mem_dest (ex_mem_dest),
    .a_fwd       (a_fwd),
    .b_fwd       (b_fwd),
    .stall       (stall)
  );

  idec_imm_gen u_imm_gen (
    .inst_word (inst_word),
    .pc_plus_4 (pc_plus_4),
    .jmp       (ctrl_dec.jmp_inst),
    .branch    (ctrl_dec.branch_inst),
    .imm_sext  (imm_sext),
    .imm       (imm)
  );

  always_comb begin
    ctrl_d       = ctrl_dec;
    ctrl_d.a_fwd = a_fwd;
    ctrl_d.b_fwd = b_fwd;
  end

  assign opnd_d = '{a: rf_rd_data1, b: rf_rd_data2, imm: imm};

  idec_stage_reg #(.payload_t(mips_pipe_pkg::id_ctrl_t)) u_ctrl_reg (
    .clock  (clock),
    .arst_n (arst_n),
    .bubble (stall),
    .d      (ctrl_d),
    .q      (ex_ctrl)
  );

  idec_stage_reg #(.payload_t(mips_pipe_pkg::id_opnd_t)) u_opnd_reg (
    .clock  (clock),
    .arst_n (arst_n),
    .bubble (stall),
    .d      (opnd_d),
    .q      (ex_opnd)
  );

endmodule

`default_nettype wire

//--- design/idec_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "idec_config.svh"

module idec_stage_reg #(
  parameter type payload_t = logic [`IDEC_XLEN-1:0]
) (
  input  logic     clock,
  input  logic     arst_n,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (bubble) begin
      q <= '0;  // zero payload is a no-op
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- design/idec_imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "idec_config.svh"

module idec_imm_gen (
  input  logic [`IDEC_XLEN-1:0] inst_word,
  input  logic [`IDEC_XLEN-1:0] pc_plus_4,
  input  logic                  jmp,
  input  logic                  branch,
  input  logic                  imm_sext,
  output logic [`IDEC_XLEN-1:0] imm
);

  logic [`IDEC_IMM_W-1:0]   imm16;
  logic [`IDEC_JADDR_W-1:0] jidx;
  logic [`IDEC_XLEN-1:0]    sext;
  logic [`IDEC_XLEN-1:0]    zext;

  assign imm16 = inst_word[`IDEC_IMM_W-1:0];
  assign jidx  = inst_word[`IDEC_JADDR_W-1:0];
  assign sext  = {{(`IDEC_XLEN-`IDEC_IMM_W){imm16[`IDEC_IMM_W-1]}}, imm16};
  assign zext  = {{(`IDEC_XLEN-`IDEC_IMM_W){1'b0}}, imm16};

  always_comb begin
    if (jmp)
      imm = {pc_plus_4[`IDEC_XLEN-1 -: 4], jidx, 2'b00};  // region of the delay slot
    else if (branch)
      imm = pc_plus_4 + {sext[`IDEC_XLEN-3:0], 2'b00};  // word offset
    else
      imm = imm_sext ? sext : zext;
  end

endmodule

`default_nettype wire

//--- design/idec_hazard.sv
`timescale 1ns/1ps
`default_nettype none

`include "idec_config.svh"

module idec_hazard (
  input  mips_pipe_pkg::src_use_t src_use,
  input  mips_pipe_pkg::dest_t    ex_dest,
  input  logic                    ex_load,
  input  mips_pipe_pkg::dest_t    ex_mem_dest,
  output mips_pipe_pkg::fwd_t     a_fwd,
  output mips_pipe_pkg::fwd_t     b_fwd,
  output logic                    stall
);

  logic a_hit_ex;
  logic a_hit_mem;
  logic b_hit_ex;
  logic b_hit_mem;

  function automatic logic hit(input logic                        used,
                               input logic [`IDEC_REG_ADDR_W-1:0] addr,
                               input mips_pipe_pkg::dest_t        dest);
    return used && dest.valid && (addr == dest.addr);
  endfunction

  assign a_hit_ex  = hit(src_use.a_used, src_use.a_addr, ex_dest);
  assign a_hit_mem = hit(src_use.a_used, src_use.a_addr, ex_mem_dest);
  assign b_hit_ex  = hit(src_use.b_used, src_use.b_addr, ex_dest);
  assign b_hit_mem = hit(src_use.b_used, src_use.b_addr, ex_mem_dest);

  // youngest producer wins
  assign a_fwd = a_hit_ex  ? mips_pipe_pkg::FWD_FROM_EXMEM :
                 a_hit_mem ? mips_pipe_pkg::FWD_FROM_MEMWB :
                             mips_pipe_pkg::FWD_NONE;

  assign b_fwd = b_hit_ex  ? (ex_load ? mips_pipe_pkg::FWD_FROM_MEMWB_LATE
                                      : mips_pipe_pkg::FWD_FROM_EXMEM) :
                 b_hit_mem ? mips_pipe_pkg::FWD_FROM_MEMWB :
                             mips_pipe_pkg::FWD_NONE;

  // load result not ready for EX, store data can wait for MEM
  assign stall = ex_load && (a_hit_ex || (b_hit_ex && !src_use.b_late));

endmodule

`default_nettype wire

//--- design/idec_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "idec_config.svh"

module idec_control (
  input  logic [`IDEC_XLEN-1:0]   inst_word,
  output mips_pipe_pkg::id_ctrl_t ctrl_dec,
  output mips_pipe_pkg::src_use_t src_use,
  output logic                    imm_sext
);

  mips_isa_pkg::inst_fields_t f;
  logic                       known;

  assign f = inst_word;

  always_comb begin
    ctrl_dec           = '0;
    src_use            = '0;
    src_use.a_addr     = f.rs;
    src_use.b_addr     = f.rt;
    ctrl_dec.dest.addr = f.rt;
    imm_sext           = 1'b0;
    known              = 1'b1;

    case (f.opc)
      mips_isa_pkg::OPC_SPECIAL: begin
        ctrl_dec.alu_inst = 1'b1;
        ctrl_dec.shamt    = f.shamt;
        ctrl_dec.dest     = '{addr: f.rd, valid: 1'b1};
        src_use.a_used    = !(f.funct inside {mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL,
                                              mips_isa_pkg::FN_SRA});  // shamt forms
        src_use.b_used    = 1'b1;
        case (f.funct)
          mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SLLV: ctrl_dec.alu_op = mips_pipe_pkg::ALU_SLL;
          mips_isa_pkg::FN_SRL, mips_isa_pkg::FN_SRLV: ctrl_dec.alu_op = mips_pipe_pkg::ALU_SRL;
          mips_isa_pkg::FN_SRA, mips_isa_pkg::FN_SRAV: ctrl_dec.alu_op = mips_pipe_pkg::ALU_SRA;
          mips_isa_pkg::FN_MOVZ: ctrl_dec.alu_op = mips_pipe_pkg::ALU_MOVZ;
          mips_isa_pkg::FN_MOVN: ctrl_dec.alu_op = mips_pipe_pkg::ALU_MOVN;
          mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU: ctrl_dec.alu_op = mips_pipe_pkg::ALU_ADD;
          mips_isa_pkg::FN_SUB, mips_isa_pkg::FN_SUBU: ctrl_dec.alu_op = mips_pipe_pkg::ALU_SUB;
          mips_isa_pkg::FN_AND: ctrl_dec.alu_op = mips_pipe_pkg::ALU_AND;
          mips_isa_pkg::FN_OR:  ctrl_dec.alu_op = mips_pipe_pkg::ALU_OR;
          mips_isa_pkg::FN_XOR: ctrl_dec.alu_op = mips_pipe_pkg::ALU_XOR;
          mips_isa_pkg::FN_NOR: ctrl_dec.alu_op = mips_pipe_pkg::ALU_NOR;
          mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLTU: begin
            ctrl_dec.alu_op      = mips_pipe_pkg::ALU_SUB;
            ctrl_dec.alu_res_sel = mips_pipe_pkg::RES_SET;
            ctrl_dec.alu_set_u   = f.funct[0];  // sltu
          end
          mips_isa_pkg::FN_JR, mips_isa_pkg::FN_JALR: begin
            ctrl_dec.alu_inst   = 1'b0;
            ctrl_dec.jmp_inst   = 1'b1;
            ctrl_dec.dest.valid = f.funct[0];  // jalr links to rd
            src_use.b_used      = 1'b0;
          end
          default: known = 1'b0;
        endcase
      end

      mips_isa_pkg::OPC_REGIMM: begin
        ctrl_dec.branch_inst = 1'b1;
        ctrl_dec.dest        = '{addr: `IDEC_LINK_REG, valid: f.rt[4]};  // al forms
        src_use.a_used       = 1'b1;
        case (f.rt)
          mips_isa_pkg::RI_BLTZ, mips_isa_pkg::RI_BLTZAL:
            ctrl_dec.branch_cond = mips_pipe_pkg::COND_LT;
          mips_isa_pkg::RI_BGEZ, mips_isa_pkg::RI_BGEZAL:
            ctrl_dec.branch_cond = mips_pipe_pkg::COND_GE;
          default: known = 1'b0;
        endcase
      end

      mips_isa_pkg::OPC_J, mips_isa_pkg::OPC_JAL: begin
        ctrl_dec.jmp_inst = 1'b1;
        ctrl_dec.dest     = '{addr: `IDEC_LINK_REG, valid: f.opc[0]};
      end

      mips_isa_pkg::OPC_BEQ, mips_isa_pkg::OPC_BNE: begin
        ctrl_dec.branch_inst = 1'b1;
        ctrl_dec.branch_cond = f.opc[0] ? mips_pipe_pkg::COND_NE : mips_pipe_pkg::COND_EQ;
        src_use.a_used       = 1'b1;
        src_use.b_used       = 1'b1;
      end

      mips_isa_pkg::OPC_BLEZ, mips_isa_pkg::OPC_BGTZ: begin
        ctrl_dec.branch_inst = 1'b1;
        ctrl_dec.branch_cond = f.opc[0] ? mips_pipe_pkg::COND_GT : mips_pipe_pkg::COND_LE;
        src_use.a_used       = 1'b1;
      end

      mips_isa_pkg::OPC_ADDI, mips_isa_pkg::OPC_ADDIU: begin
        ctrl_dec.alu_op = mips_pipe_pkg::ALU_ADD;
        imm_sext        = 1'b1;
      end

      mips_isa_pkg::OPC_SLTI, mips_isa_pkg::OPC_SLTIU: begin
        ctrl_dec.alu_op      = mips_pipe_pkg::ALU_SUB;
        ctrl_dec.alu_res_sel = mips_pipe_pkg::RES_SET;
        ctrl_dec.alu_set_u   = f.opc[0];
        imm_sext             = 1'b1;
      end

      mips_isa_pkg::OPC_ANDI: ctrl_dec.alu_op = mips_pipe_pkg::ALU_AND;
      mips_isa_pkg::OPC_ORI:  ctrl_dec.alu_op = mips_pipe_pkg::ALU_OR;
      mips_isa_pkg::OPC_XORI: ctrl_dec.alu_op = mips_pipe_pkg::ALU_XOR;
      mips_isa_pkg::OPC_LUI:  ctrl_dec.alu_op = mips_pipe_pkg::ALU_LUI;

      mips_isa_pkg::OPC_SPECIAL3: begin
        ctrl_dec.alu_inst = 1'b1;
        ctrl_dec.dest     = '{addr: f.rd, valid: 1'b1};
        src_use.b_used    = 1'b1;
        if (f.funct == mips_isa_pkg::BSHFL_FUNCT && f.shamt == mips_isa_pkg::SEB_SA)
          ctrl_dec.alu_op = mips_pipe_pkg::ALU_SEB;
        else if (f.funct == mips_isa_pkg::BSHFL_FUNCT && f.shamt == mips_isa_pkg::SEH_SA)
          ctrl_dec.alu_op = mips_pipe_pkg::ALU_SEH;
        else
          known = 1'b0;
      end

      mips_isa_pkg::OPC_LB, mips_isa_pkg::OPC_LH, mips_isa_pkg::OPC_LW,
      mips_isa_pkg::OPC_LBU, mips_isa_pkg::OPC_LHU: begin
        ctrl_dec.load_inst  = 1'b1;
        ctrl_dec.ls_sext    = f.opc inside {mips_isa_pkg::OPC_LB, mips_isa_pkg::OPC_LH};
        ctrl_dec.dest.valid = 1'b1;
      end

      mips_isa_pkg::OPC_SB, mips_isa_pkg::OPC_SH, mips_isa_pkg::OPC_SW: begin
        ctrl_dec.store_inst  = 1'b1;
        ctrl_dec.b_need_late = 1'b1;
        src_use.b_used       = 1'b1;
        src_use.b_late       = 1'b1;
      end

      default: known = 1'b0;
    endcase

    // immediate alu forms, lui reads no register
    if (f.opc inside {[mips_isa_pkg::OPC_ADDI : mips_isa_pkg::OPC_LUI]}) begin
      ctrl_dec.alu_inst   = 1'b1;
      ctrl_dec.dest.valid = 1'b1;
      src_use.a_used      = (f.opc != mips_isa_pkg::OPC_LUI);
    end

    // address add for loads and stores, size from low opcode bits
    if (ctrl_dec.load_inst || ctrl_dec.store_inst) begin
      ctrl_dec.alu_op = mips_pipe_pkg::ALU_ADD;
      imm_sext        = 1'b1;
      src_use.a_used  = 1'b1;
      ctrl_dec.ls_op  = (f.opc[1:0] == 2'b00) ? mips_pipe_pkg::LS_BYTE :
                        (f.opc[1:0] == 2'b01) ? mips_pipe_pkg::LS_HALFWORD :
                                                mips_pipe_pkg::LS_WORD;
    end

    if (ctrl_dec.dest.addr == '0)
      ctrl_dec.dest.valid = 1'b0;  // $0 is never written

    if (!known) begin
      ctrl_dec = '0;
      src_use  = '0;
      imm_sext = 1'b0;
    end

    ctrl_dec.imm_valid = !(f.opc inside {mips_isa_pkg::OPC_SPECIAL, mips_isa_pkg::OPC_SPECIAL2,
                                         mips_isa_pkg::OPC_SPECIAL3});
  end

endmodule

`default_nettype wire

//--- design/mips_pipe_pkg.sv
`default_nettype none

`include "idec_config.svh"

package mips_pipe_pkg;

  typedef enum logic [3:0] {
    ALU_PASS_A = 4'd0,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_MOVZ,
    ALU_MOVN,
    ALU_LUI,
    ALU_SEB,
    ALU_SEH
  } alu_op_t;

  typedef enum logic {RES_ALU, RES_SET} alu_res_t;

  typedef enum logic [1:0] {LS_WORD, LS_BYTE, LS_HALFWORD} ls_op_t;

  typedef enum logic [2:0] {
    COND_UNCONDITIONAL = 3'd0,
    COND_EQ,
    COND_NE,
    COND_LT,
    COND_GE,
    COND_LE,
    COND_GT
  } cond_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_FROM_EXMEM,
    FWD_FROM_MEMWB,
    FWD_FROM_MEMWB_LATE  // load data, only for late B
  } fwd_t;

  typedef struct packed {
    logic [`IDEC_REG_ADDR_W-1:0] addr;
    logic                        valid;
  } dest_t;

  typedef struct packed {
    logic [`IDEC_REG_ADDR_W-1:0] a_addr;
    logic                        a_used;
    logic [`IDEC_REG_ADDR_W-1:0] b_addr;
    logic                        b_used;
    logic                        b_late;  // store data, needed in MEM
  } src_use_t;

  // all zero is a bubble
  typedef struct packed {
    alu_op_t                     alu_op;
    alu_res_t                    alu_res_sel;
    logic                        alu_set_u;
    ls_op_t                      ls_op;
    logic                        ls_sext;
    cond_t                       branch_cond;
    logic                        alu_inst;
    logic                        load_inst;
    logic                        store_inst;
    logic                        jmp_inst;
    logic                        branch_inst;
    dest_t                       dest;
    logic [`IDEC_REG_ADDR_W-1:0] shamt;
    fwd_t                        a_fwd;
    fwd_t                        b_fwd;
    logic                        b_need_late;
    logic                        imm_valid;
  } id_ctrl_t;

  typedef struct packed {
    logic [`IDEC_XLEN-1:0] a;
    logic [`IDEC_XLEN-1:0] b;
    logic [`IDEC_XLEN-1:0] imm;
  } id_opnd_t;

endpackage

`default_nettype wire

//--- design/mips_isa_pkg.sv
`default_nettype none

`include "idec_config.svh"

package mips_isa_pkg;

  typedef enum logic [`IDEC_OPC_W-1:0] {
    OPC_SPECIAL  = 6'h00,
    OPC_REGIMM   = 6'h01,
    OPC_J        = 6'h02,
    OPC_JAL      = 6'h03,
    OPC_BEQ      = 6'h04,
    OPC_BNE      = 6'h05,
    OPC_BLEZ     = 6'h06,
    OPC_BGTZ     = 6'h07,
    OPC_ADDI     = 6'h08,
    OPC_ADDIU    = 6'h09,
    OPC_SLTI     = 6'h0a,
    OPC_SLTIU    = 6'h0b,
    OPC_ANDI     = 6'h0c,
    OPC_ORI      = 6'h0d,
    OPC_XORI     = 6'h0e,
    OPC_LUI      = 6'h0f,
    OPC_SPECIAL2 = 6'h1c,  // no kept encodings
    OPC_SPECIAL3 = 6'h1f,
    OPC_LB       = 6'h20,
    OPC_LH       = 6'h21,
    OPC_LW       = 6'h23,
    OPC_LBU      = 6'h24,
    OPC_LHU      = 6'h25,
    OPC_SB       = 6'h28,
    OPC_SH       = 6'h29,
    OPC_SW       = 6'h2b
  } opcode_e;

  typedef enum logic [`IDEC_OPC_W-1:0] {
    FN_SLL  = 6'd0,
    FN_SRL  = 6'd2,
    FN_SRA  = 6'd3,
    FN_SLLV = 6'd4,
    FN_SRLV = 6'd6,
    FN_SRAV = 6'd7,
    FN_JR   = 6'd8,
    FN_JALR = 6'd9,
    FN_MOVZ = 6'd10,
    FN_MOVN = 6'd11,
    FN_ADD  = 6'd32,
    FN_ADDU = 6'd33,
    FN_SUB  = 6'd34,
    FN_SUBU = 6'd35,
    FN_AND  = 6'd36,
    FN_OR   = 6'd37,
    FN_XOR  = 6'd38,
    FN_NOR  = 6'd39,
    FN_SLT  = 6'd42,
    FN_SLTU = 6'd43
  } funct_e;

  // rt field under REGIMM
  typedef enum logic [`IDEC_REG_ADDR_W-1:0] {
    RI_BLTZ   = 5'h00,
    RI_BGEZ   = 5'h01,
    RI_BLTZAL = 5'h10,
    RI_BGEZAL = 5'h11
  } regimm_e;

  // bshfl group under SPECIAL3, sub-op sits in shamt
  localparam logic [`IDEC_OPC_W-1:0]      BSHFL_FUNCT = 6'd32;
  localparam logic [`IDEC_REG_ADDR_W-1:0] SEB_SA      = 5'd16;
  localparam logic [`IDEC_REG_ADDR_W-1:0] SEH_SA      = 5'd24;

  typedef struct packed {
    logic [`IDEC_OPC_W-1:0]      opc;
    logic [`IDEC_REG_ADDR_W-1:0] rs;
    logic [`IDEC_REG_ADDR_W-1:0] rt;
    logic [`IDEC_REG_ADDR_W-1:0] rd;
    logic [`IDEC_REG_ADDR_W-1:0] shamt;
    logic [`IDEC_OPC_W-1:0]      funct;
  } inst_fields_t;

endpackage

`default_nettype wire

//--- design/idec_config.svh
`ifndef IDEC_CONFIG_SVH
`define IDEC_CONFIG_SVH

// datapath width
`define IDEC_XLEN        32

// register file address width
`define IDEC_REG_ADDR_W  5

// opcode and funct fields share one width
`define IDEC_OPC_W       6

`define IDEC_IMM_W       16
`define IDEC_JADDR_W     26

// written by jal, bltzal and bgezal
`define IDEC_LINK_REG    31

`endif
